// ==== sources.f ====
rtl/dmaPkg.sv
rtl/dmaRegFile.sv
rtl/dmaFifo.sv
rtl/dmaXferEngine.sv
rtl/dmaChainLoader.sv
rtl/dmaPortMux.sv
rtl/dmaTop.sv
verif/dmaTb.sv
verif/dmaTb_sva.sv

// ==== verif/dmaTb_sva.sv ====
`timescale 1ns/10ps

module dmaTopSva #(
  parameter int AdrWidth  = dmaPkg::AdrWidth,
  parameter int DataWidth = dmaPkg::DataWidth
) (
  input logic                 clk,
  input logic                 rst,
  input logic                 nearEn,
  input logic                 nearWe,
  input logic [AdrWidth-1:0]  nearAdr,
  input logic [DataWidth-1:0] nearDatOut,
  input logic                 nearBusy,
  input logic                 sysEn,
  input logic                 sysWe,
  input logic [AdrWidth-1:0]  sysAdr,
  input logic [DataWidth-1:0] sysDatOut,
  input logic                 sysBusy
);

  int failCount = 0; // failed assertion count

  enInReset: assert property (@(posedge clk) rst |-> (!nearEn && !sysEn))
  else
  begin
    failCount++;
    $error("port enable high while in reset");
  end

  // a stalled access keeps its request unchanged
  nearHold: assert property (@(posedge clk) disable iff (rst)
    (nearEn && nearBusy) |=>
      (nearEn && $stable(nearWe) && $stable(nearAdr) && $stable(nearDatOut)))
  else
  begin
    failCount++;
    $error("near port request changed while busy");
  end

  sysHold: assert property (@(posedge clk) disable iff (rst)
    (sysEn && sysBusy) |=>
      (sysEn && $stable(sysWe) && $stable(sysAdr) && $stable(sysDatOut)))
  else
  begin
    failCount++;
    $error("system port request changed while busy");
  end

endmodule

bind dmaTop dmaTopSva #(.AdrWidth(AdrWidth), .DataWidth(DataWidth)) u_dmaTopSva (
  .clk(clk), .rst(rst), .nearEn(nearEn), .nearWe(nearWe), .nearAdr(nearAdr),
  .nearDatOut(nearDatOut), .nearBusy(nearBusy), .sysEn(sysEn), .sysWe(sysWe),
  .sysAdr(sysAdr), .sysDatOut(sysDatOut), .sysBusy(sysBusy));

// ==== verif/dmaTb.sv ====
`timescale 1ns/10ps

module dmaTb;
  import dmaPkg::*;

  localparam int MemWords = 256;

  typedef struct {
    string       name;
    logic [1:0]  dir;
    logic [1:0]  mode;
    logic [15:0] srcIdx;
    logic [15:0] srcMod;
    logic [15:0] count;
    logic [15:0] dstIdx;
    logic [15:0] dstMod;
    logic [15:0] chainPtr;
    bit          busy;
  } CaseRow;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        cfgWe = 1'b0;
  logic [15:0] cfgAdr = '0;
  logic [15:0] cfgDat = '0;
  logic        nearBusy = 1'b0;
  logic        sysBusy = 1'b0;
  logic [15:0] nearDatIn;
  logic [15:0] sysDatIn;
  logic        nearEn;
  logic        nearWe;
  logic [15:0] nearAdr;
  logic [15:0] nearDatOut;
  logic        sysEn;
  logic        sysWe;
  logic [15:0] sysAdr;
  logic [15:0] sysDatOut;
  logic        active;

  logic [15:0] nearMem [MemWords];
  logic [15:0] sysMem [MemWords];
  logic [15:0] expNear [MemWords];
  logic [15:0] expSys [MemWords];
  CaseRow      caseTable [$];
  integer      seed = 32'ha584_6cca;
  logic [31:0] rndWord;
  bit          busyOn = 1'b0;
  int          cycleCount = 0;
  int          cycleLimit = 0;
  int          accessCount = 0;

  dmaTop u_dmaTop (
    .clk(clk), .rst(rst), .cfgWe(cfgWe), .cfgAdr(cfgAdr), .cfgDat(cfgDat),
    .nearDatIn(nearDatIn), .nearBusy(nearBusy), .sysDatIn(sysDatIn), .sysBusy(sysBusy),
    .nearEn(nearEn), .nearWe(nearWe), .nearAdr(nearAdr), .nearDatOut(nearDatOut),
    .sysEn(sysEn), .sysWe(sysWe), .sysAdr(sysAdr), .sysDatOut(sysDatOut), .active(active));

  always #2 clk = ~clk; // 4 ns period

  assign nearDatIn = nearMem[nearAdr[7:0]]; // low byte selects the word
  assign sysDatIn  = sysMem[sysAdr[7:0]];

  // an access completes where en is high and busy is low
  always @(posedge clk)
  begin
    if (nearEn && nearWe && !nearBusy)
      nearMem[nearAdr[7:0]] <= nearDatOut;
    if (sysEn && sysWe && !sysBusy)
      sysMem[sysAdr[7:0]] <= sysDatOut;
    accessCount <= accessCount + int'(nearEn && !nearBusy) + int'(sysEn && !sysBusy);
  end

  always @(posedge clk)
  begin
    #1;
    rndWord = $random(seed);
    nearBusy = busyOn && rndWord[0];
    sysBusy  = busyOn && rndWord[1];
  end

  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount > cycleLimit)
    begin
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation timeout");
    end
  end

  // stops at the first failed handshake assertion
  always @(posedge clk)
  begin
    if (u_dmaTop.u_dmaTopSva.failCount != 0)
    begin
      $display("a port handshake assertion failed");
      $display("*** TEST FAILED ***");
      $fatal(1, "handshake assertion failure");
    end
  end

  function automatic logic [15:0] fillWord(input bit sysPort, input logic [7:0] adr,
                                           input int caseNum);
    logic [7:0] key;
    key = (sysPort ? 8'hC3 : 8'h5A) ^ 8'(caseNum * 17); // differs per port and case
    return {adr ^ key, adr};
  endfunction

  function automatic logic [15:0] ctrlWord(input logic [1:0] mode, input logic [1:0] dir);
    return {10'd0, mode, dir, 1'b0, 1'b1}; // enable in bit 0
  endfunction

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected)
    else
    begin
      $display("CHECK FAILED %s: expected %0h, actual %0h", what, expected, actual);
      $display("*** TEST FAILED ***");
      $fatal(1, "mismatch in %s", what);
    end
  endtask

  task automatic addCase(input string name, input logic [1:0] dir, input logic [1:0] mode,
                         input logic [15:0] srcIdx, input logic [15:0] srcMod,
                         input logic [15:0] count, input logic [15:0] dstIdx,
                         input logic [15:0] dstMod, input logic [15:0] chainPtr,
                         input bit busy);
    caseTable.push_back('{name, dir, mode, srcIdx, srcMod, count, dstIdx, dstMod,
                          chainPtr, busy});
    cycleLimit += 40 * (mode == ModeChain ? 2 : 1) * int'(count) + 100;
  endtask

  task automatic buildTable();
    addCase("nearNear", DirNearNear, ModeNormal, 16'h10, 16'h1, 16'd8, 16'h80, 16'h1, 0, 0);
    addCase("nearSys", DirNearSys, ModeNormal, 16'h20, 16'h1, 16'd6, 16'h30, 16'h1, 0, 0);
    addCase("sysNear", DirSysNear, ModeNormal, 16'h40, 16'h1, 16'd9, 16'h90, 16'h1, 0, 0);
    addCase("sysSys", DirSysSys, ModeNormal, 16'h50, 16'h1, 16'd5, 16'hC0, 16'h1, 0, 0);
    addCase("nearSysMod23", DirNearSys, ModeNormal, 16'h10, 16'h2, 16'd7, 16'h40, 16'h3, 0, 0);
    addCase("sysNearMod32", DirSysNear, ModeNormal, 16'h20, 16'h3, 16'd6, 16'hA0, 16'h2, 0, 0);
    addCase("nearSysBusy", DirNearSys, ModeNormal, 16'h10, 16'h2, 16'd7, 16'h40, 16'h3, 0, 1);
    addCase("sysNearBusy", DirSysNear, ModeNormal, 16'h20, 16'h3, 16'd6, 16'hA0, 16'h2, 0, 1);
    addCase("nearNearBusy", DirNearNear, ModeNormal, 16'h08, 16'h2, 16'd10, 16'h70, 16'h3, 0, 1);
    addCase("chainTwo", DirNearSys, ModeChain, 16'h10, 16'h1, 16'd5, 16'h20, 16'h1, 16'hE0, 1);
    addCase("zeroCount", DirSysNear, ModeNormal, 16'h30, 16'h1, 16'd0, 16'h30, 16'h1, 0, 0);
  endtask

  task automatic writeReg(input logic [15:0] adr, input logic [15:0] dat);
    @(posedge clk);
    #1;
    cfgWe  = 1'b1;
    cfgAdr = adr;
    cfgDat = dat;
    @(posedge clk);
    #1;
    cfgWe = 1'b0;
  endtask

  task automatic placeDescriptor(input logic [7:0] at, input CaseRow row,
                                 input logic [15:0] offset, input logic [15:0] next);
    nearMem[8'(at + 0)] = row.srcIdx + offset;
    nearMem[8'(at + 1)] = row.srcMod;
    nearMem[8'(at + 2)] = row.count;
    nearMem[8'(at + 3)] = next; // null ends the chain
    nearMem[8'(at + 4)] = row.dstIdx + offset;
    nearMem[8'(at + 5)] = row.dstMod;
    nearMem[8'(at + 6)] = row.count;
  endtask

  task automatic prepareMemories(input int c);
    CaseRow      row;
    logic [7:0]  sa;
    logic [7:0]  da;
    logic [15:0] word;
    int          blocks;
    row = caseTable[c];
    for (int a = 0; a < MemWords; a++)
    begin
      nearMem[a] = fillWord(1'b0, 8'(a), c);
      sysMem[a]  = fillWord(1'b1, 8'(a), c);
    end
    if (row.mode == ModeChain)
    begin
      placeDescriptor(row.chainPtr[7:0], row, 16'h0, row.chainPtr + 16'd8);
      placeDescriptor(8'(row.chainPtr + 8), row, 16'h40, 16'h0);
    end
    expNear = nearMem;
    expSys  = sysMem;
    blocks  = (row.mode == ModeChain) ? 2 : 1;
    for (int b = 0; b < blocks; b++)
      for (int i = 0; i < int'(row.count); i++)
      begin
        sa   = 8'(row.srcIdx + b * 64 + i * row.srcMod);
        da   = 8'(row.dstIdx + b * 64 + i * row.dstMod);
        word = row.dir[1] ? sysMem[sa] : nearMem[sa];
        if (row.dir[0])
          expSys[da] = word;
        else
          expNear[da] = word;
      end
  endtask

  task automatic runCase(input int c);
    CaseRow row;
    int     expAccesses;
    row = caseTable[c];
    prepareMemories(c);
    busyOn = row.busy;
    writeReg(RegSrcIdx, row.srcIdx);
    writeReg(RegSrcMod, row.srcMod);
    writeReg(RegSrcCnt, row.count);
    writeReg(RegDstIdx, row.dstIdx);
    writeReg(RegDstMod, row.dstMod);
    writeReg(RegDstCnt, row.count);
    writeReg(RegChainPtr, row.chainPtr);
    accessCount = 0;
    writeReg(RegCtrl, ctrlWord(row.mode, row.dir));
    checkValue({row.name, " active after start"}, 1, active);
    while (active)
    begin
      @(posedge clk);
      #1;
    end
    busyOn = 1'b0;
    if (row.mode == ModeChain)
      expAccesses = 2 * (DescWords + 2 * int'(row.count)); // two descriptors and two blocks
    else
      expAccesses = 2 * int'(row.count);
    checkValue({row.name, " access count"}, expAccesses, accessCount);
    for (int a = 0; a < MemWords; a++)
    begin
      checkValue($sformatf("%s near[%02h]", row.name, a), expNear[a], nearMem[a]);
      checkValue($sformatf("%s sys[%02h]", row.name, a), expSys[a], sysMem[a]);
    end
  endtask

  initial
  begin
    buildTable();
    repeat (4) @(posedge clk);
    checkValue("nearEn in reset", 0, nearEn);
    checkValue("sysEn in reset", 0, sysEn);
    #1;
    rst = 1'b0;
    checkValue("active after reset", 0, active);
    for (int c = 0; c < caseTable.size(); c++)
      runCase(c);
    if (u_dmaTop.u_dmaTopSva.failCount == 0)
    begin
      $display("*** TEST PASSED ***");
      $finish;
    end
    else
    begin
      $display("%0d port handshake assertions failed", u_dmaTop.u_dmaTopSva.failCount);
      $display("*** TEST FAILED ***");
      $fatal(1, "handshake assertion failures");
    end
  end

endmodule

// ==== rtl/dmaTop.sv ====
`timescale 1ns/10ps

module dmaTop #(
  parameter int AdrWidth  = dmaPkg::AdrWidth,
  parameter int DataWidth = dmaPkg::DataWidth,
  parameter int DepthLog2 = dmaPkg::DepthLog2
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cfgWe,
  input  logic [AdrWidth-1:0]  cfgAdr,
  input  logic [DataWidth-1:0] cfgDat,
  input  logic [DataWidth-1:0] nearDatIn,
  input  logic                 nearBusy,
  input  logic [DataWidth-1:0] sysDatIn,
  input  logic                 sysBusy,
  output logic                 nearEn,
  output logic                 nearWe,
  output logic [AdrWidth-1:0]  nearAdr,
  output logic [DataWidth-1:0] nearDatOut,
  output logic                 sysEn,
  output logic                 sysWe,
  output logic [AdrWidth-1:0]  sysAdr,
  output logic [DataWidth-1:0] sysDatOut,
  output logic                 active
);
  import dmaPkg::*;

  localparam int CtrlWidth = $bits(dmaCtrl_u);

  dmaCtrl_u             ctrl;
  dmaCtrl_u             cfgCtrl;
  logic [AdrWidth-1:0]  srcIdx, dstIdx, chainPtr, srcAdr, dstAdr, ldAdr;
  logic [DataWidth-1:0] srcCnt, dstCnt, rdData, dstDat, fifoDat, fifoPushDat;
  RegSel                ldSel;
  logic                 srcStep, dstStep, clrEnable, ldWe, ldReq, ldDone, loading;
  logic                 srcReq, dstReq, srcDone, dstDone, xferDone, run;
  logic                 fifoPush, fifoPop, fifoEmpty, fifoFull;
  logic                 chainMode, chainNext, kick, restart, loadStart;

  assign cfgCtrl.raw = CtrlWidth'(cfgDat); // control word being written
  assign chainMode   = (ctrl.f.mode == ModeChain);
  assign chainNext   = (chainPtr != '0);

  // loader starts on the enabling write or after each chained block
  assign kick = cfgWe && (cfgAdr == RegCtrl) && cfgCtrl.f.enable &&
                (cfgCtrl.f.mode == ModeChain) && chainNext;
  assign restart   = xferDone && chainMode && chainNext;
  assign loadStart = kick || restart;
  assign clrEnable = xferDone && !restart;
  assign run       = ctrl.f.enable && !loading;
  assign active    = ctrl.f.enable;

  dmaRegFile #(.AdrWidth(AdrWidth), .DataWidth(DataWidth)) u_dmaRegFile (
    .clk(clk), .rst(rst), .cfgWe(cfgWe), .cfgAdr(cfgAdr), .cfgDat(cfgDat),
    .ldWe(ldWe), .ldSel(ldSel), .ldDat(rdData), .srcStep(srcStep), .dstStep(dstStep),
    .clrEnable(clrEnable), .ctrl(ctrl), .srcIdx(srcIdx), .dstIdx(dstIdx),
    .srcCnt(srcCnt), .dstCnt(dstCnt), .chainPtr(chainPtr));

  dmaFifo #(.DataWidth(DataWidth), .DepthLog2(DepthLog2)) u_dmaFifo (
    .clk(clk), .rst(rst), .push(fifoPush), .pushDat(fifoPushDat), .pop(fifoPop),
    .popDat(fifoDat), .empty(fifoEmpty), .full(fifoFull));

  dmaXferEngine #(.AdrWidth(AdrWidth), .DataWidth(DataWidth)) u_dmaXferEngine (
    .clk(clk), .rst(rst), .run(run), .srcIdx(srcIdx), .dstIdx(dstIdx),
    .srcCnt(srcCnt), .dstCnt(dstCnt), .srcDone(srcDone), .dstDone(dstDone),
    .rdData(rdData), .fifoEmpty(fifoEmpty), .fifoFull(fifoFull), .fifoDat(fifoDat),
    .srcReq(srcReq), .srcAdr(srcAdr), .dstReq(dstReq), .dstAdr(dstAdr), .dstDat(dstDat),
    .srcStep(srcStep), .dstStep(dstStep), .fifoPush(fifoPush),
    .fifoPushDat(fifoPushDat), .fifoPop(fifoPop), .xferDone(xferDone));

  dmaChainLoader #(.AdrWidth(AdrWidth)) u_dmaChainLoader (
    .clk(clk), .rst(rst), .start(loadStart), .chainPtr(chainPtr), .ldDone(ldDone),
    .ldReq(ldReq), .ldAdr(ldAdr), .ldWe(ldWe), .ldSel(ldSel), .loading(loading));

  dmaPortMux #(.AdrWidth(AdrWidth), .DataWidth(DataWidth)) u_dmaPortMux (
    .ctrl(ctrl), .loading(loading), .srcReq(srcReq), .srcAdr(srcAdr),
    .dstReq(dstReq), .dstAdr(dstAdr), .dstDat(dstDat), .ldReq(ldReq), .ldAdr(ldAdr),
    .nearBusy(nearBusy), .nearDatIn(nearDatIn), .sysBusy(sysBusy), .sysDatIn(sysDatIn),
    .srcDone(srcDone), .dstDone(dstDone), .ldDone(ldDone), .rdData(rdData),
    .nearEn(nearEn), .nearWe(nearWe), .nearAdr(nearAdr), .nearDatOut(nearDatOut),
    .sysEn(sysEn), .sysWe(sysWe), .sysAdr(sysAdr), .sysDatOut(sysDatOut));

endmodule

// ==== rtl/dmaPortMux.sv ====
`timescale 1ns/10ps

module dmaPortMux #(
  parameter int AdrWidth  = dmaPkg::AdrWidth,
  parameter int DataWidth = dmaPkg::DataWidth
) (
  input  dmaPkg::dmaCtrl_u     ctrl,
  input  logic                 loading,
  input  logic                 srcReq,
  input  logic [AdrWidth-1:0]  srcAdr,
  input  logic                 dstReq,
  input  logic [AdrWidth-1:0]  dstAdr,
  input  logic [DataWidth-1:0] dstDat,
  input  logic                 ldReq,
  input  logic [AdrWidth-1:0]  ldAdr,
  input  logic                 nearBusy,
  input  logic [DataWidth-1:0] nearDatIn,
  input  logic                 sysBusy,
  input  logic [DataWidth-1:0] sysDatIn,
  output logic                 srcDone,
  output logic                 dstDone,
  output logic                 ldDone,
  output logic [DataWidth-1:0] rdData,
  output logic                 nearEn,
  output logic                 nearWe,
  output logic [AdrWidth-1:0]  nearAdr,
  output logic [DataWidth-1:0] nearDatOut,
  output logic                 sysEn,
  output logic                 sysWe,
  output logic [AdrWidth-1:0]  sysAdr,
  output logic [DataWidth-1:0] sysDatOut
);
  import dmaPkg::*;

  logic srcSys;
  logic dstSys;
  logic engSrc;
  logic engDst;

  always_comb
  begin
    case (ctrl.f.dir)
      DirNearNear: {srcSys, dstSys} = 2'b00;
      DirNearSys:  {srcSys, dstSys} = 2'b01;
      DirSysNear:  {srcSys, dstSys} = 2'b10;
      default:     {srcSys, dstSys} = 2'b11;
    endcase
  end

  // destination wins a shared port
  assign engDst = !loading && dstReq;
  assign engSrc = !loading && srcReq && !(dstReq && (srcSys == dstSys));

  always_comb
  begin
    nearEn = 1'b0;
    nearWe = 1'b0;
    nearAdr = '0;
    nearDatOut = '0;
    sysEn = 1'b0;
    sysWe = 1'b0;
    sysAdr = '0;
    sysDatOut = '0;
    if (loading)
    begin
      nearEn  = ldReq; // descriptors live in near memory
      nearAdr = ldAdr;
    end
    else
    begin
      if (engDst && !dstSys)
      begin
        nearEn = 1'b1;
        nearWe = 1'b1;
        nearAdr = dstAdr;
        nearDatOut = dstDat;
      end
      else if (engSrc && !srcSys)
      begin
        nearEn  = 1'b1;
        nearAdr = srcAdr;
      end
      if (engDst && dstSys)
      begin
        sysEn = 1'b1;
        sysWe = 1'b1;
        sysAdr = dstAdr;
        sysDatOut = dstDat;
      end
      else if (engSrc && srcSys)
      begin
        sysEn  = 1'b1;
        sysAdr = srcAdr;
      end
    end
  end

  assign srcDone = engSrc && !(srcSys ? sysBusy : nearBusy);
  assign dstDone = engDst && !(dstSys ? sysBusy : nearBusy);
  assign ldDone  = loading && ldReq && !nearBusy;
  assign rdData  = (loading || !srcSys) ? nearDatIn : sysDatIn;

endmodule

// ==== rtl/dmaChainLoader.sv ====
`timescale 1ns/10ps

module dmaChainLoader #(
  parameter int AdrWidth = dmaPkg::AdrWidth
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  logic [AdrWidth-1:0] chainPtr,
  input  logic                ldDone,
  output logic                ldReq,
  output logic [AdrWidth-1:0] ldAdr,
  output logic                ldWe,
  output dmaPkg::RegSel       ldSel,
  output logic                loading
);
  import dmaPkg::*;

  localparam RegSel LastSel = RegSel'(DescWords - 1);

  logic [AdrWidth-1:0] curAdr;
  RegSel               wordSel;

  // pointer is copied at start since word 3 overwrites chainPtr
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      loading <= 1'b0;
      curAdr  <= '0;
      wordSel <= '0;
    end
    else if (!loading)
    begin
      if (start)
      begin
        loading <= 1'b1;
        curAdr  <= chainPtr;
        wordSel <= '0;
      end
    end
    else if (ldDone)
    begin
      curAdr <= curAdr + 1'b1;
      if (wordSel == LastSel)
      begin
        loading <= 1'b0; // descriptor complete, engine may run
        wordSel <= '0;
      end
      else
        wordSel <= wordSel + 1'b1;
    end
  end

  assign ldReq = loading;
  assign ldAdr = curAdr;
  assign ldWe  = loading && ldDone; // one register per completed read
  assign ldSel = wordSel;

endmodule

// ==== rtl/dmaXferEngine.sv ====
`timescale 1ns/10ps

module dmaXferEngine #(
  parameter int AdrWidth  = dmaPkg::AdrWidth,
  parameter int DataWidth = dmaPkg::DataWidth
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 run,
  input  logic [AdrWidth-1:0]  srcIdx,
  input  logic [AdrWidth-1:0]  dstIdx,
  input  logic [DataWidth-1:0] srcCnt,
  input  logic [DataWidth-1:0] dstCnt,
  input  logic                 srcDone,
  input  logic                 dstDone,
  input  logic [DataWidth-1:0] rdData,
  input  logic                 fifoEmpty,
  input  logic                 fifoFull,
  input  logic [DataWidth-1:0] fifoDat,
  output logic                 srcReq,
  output logic [AdrWidth-1:0]  srcAdr,
  output logic                 dstReq,
  output logic [AdrWidth-1:0]  dstAdr,
  output logic [DataWidth-1:0] dstDat,
  output logic                 srcStep,
  output logic                 dstStep,
  output logic                 fifoPush,
  output logic [DataWidth-1:0] fifoPushDat,
  output logic                 fifoPop,
  output logic                 xferDone
);

  localparam logic [1:0] StIdle  = 2'd0;
  localparam logic [1:0] StRead  = 2'd1;
  localparam logic [1:0] StWrite = 2'd2;
  localparam logic [1:0] StDone  = 2'd3;

  logic [1:0] state;
  logic [1:0] nextState;
  logic       srcAvail;
  logic       dstAvail;
  logic       allDone;

  // filling has priority, draining starts when full or source is exhausted
  assign srcAvail = run && (srcCnt != '0) && !fifoFull;
  assign dstAvail = run && (dstCnt != '0) && !fifoEmpty;
  assign allDone  = run && (srcCnt == '0) && (dstCnt == '0);

  always_comb
  begin
    nextState = state;
    case (state)
      StIdle:
      begin
        if (srcAvail)
          nextState = StRead;
        else if (dstAvail)
          nextState = StWrite;
        else if (allDone)
          nextState = StDone; // also taken at once for zero counts
      end
      StRead:
      begin
        if (srcDone)
          nextState = StIdle; // counts settle before the next decision
      end
      StWrite:
      begin
        if (dstDone)
          nextState = StIdle;
      end
      default:
        nextState = StIdle;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= StIdle;
    else
      state <= nextState;
  end

  // request holds until the access completes, so the port stays stable
  assign srcReq = (state == StRead);
  assign dstReq = (state == StWrite);
  assign srcAdr = srcIdx;
  assign dstAdr = dstIdx;
  assign dstDat = fifoDat; // head is not disturbed while writing

  assign srcStep     = srcReq && srcDone;
  assign fifoPush    = srcReq && srcDone;
  assign fifoPushDat = rdData; // sampled on the completing edge
  assign dstStep     = dstReq && dstDone;
  assign fifoPop     = dstReq && dstDone;

  assign xferDone = (state == StDone);

endmodule

// ==== rtl/dmaFifo.sv ====
`timescale 1ns/10ps

module dmaFifo #(
  parameter int DataWidth = dmaPkg::DataWidth,
  parameter int DepthLog2 = dmaPkg::DepthLog2
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 push,
  input  logic [DataWidth-1:0] pushDat,
  input  logic                 pop,
  output logic [DataWidth-1:0] popDat,
  output logic                 empty,
  output logic                 full
);

  localparam int Depth = 2 ** DepthLog2;

  logic [DataWidth-1:0] mem [Depth];
  logic [DepthLog2-1:0] wrPtr;
  logic [DepthLog2-1:0] rdPtr;
  logic [DepthLog2:0]   count;
  logic                 doPush;
  logic                 doPop;

  assign doPush = push && !full; // overflow is dropped
  assign doPop  = pop && !empty;

  always_ff @(posedge clk)
  begin
    if (doPush)
      mem[wrPtr] <= pushDat;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= wrPtr + 1'b1; // wraps at depth
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  assign popDat = mem[rdPtr]; // head word, registered storage
  assign empty  = (count == '0);
  assign full   = (count == (DepthLog2 + 1)'(Depth));

endmodule

// ==== rtl/dmaRegFile.sv ====
`timescale 1ns/10ps

module dmaRegFile #(
  parameter int AdrWidth  = dmaPkg::AdrWidth,
  parameter int DataWidth = dmaPkg::DataWidth
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cfgWe,
  input  logic [AdrWidth-1:0]  cfgAdr,
  input  logic [DataWidth-1:0] cfgDat,
  input  logic                 ldWe,
  input  dmaPkg::RegSel        ldSel,
  input  logic [DataWidth-1:0] ldDat,
  input  logic                 srcStep,
  input  logic                 dstStep,
  input  logic                 clrEnable,
  output dmaPkg::dmaCtrl_u     ctrl,
  output logic [AdrWidth-1:0]  srcIdx,
  output logic [AdrWidth-1:0]  dstIdx,
  output logic [DataWidth-1:0] srcCnt,
  output logic [DataWidth-1:0] dstCnt,
  output logic [AdrWidth-1:0]  chainPtr
);
  import dmaPkg::*;

  localparam int CtrlWidth = $bits(dmaCtrl_u);

  logic [AdrWidth-1:0] srcMod;
  logic [AdrWidth-1:0] dstMod;
  logic [AdrWidth-1:0] cfgAdrDat;
  logic [AdrWidth-1:0] ldAdrDat;

  assign cfgAdrDat = AdrWidth'(cfgDat); // data word used as an address
  assign ldAdrDat  = AdrWidth'(ldDat);

  // later assignments win: stepping, then descriptor loads, then software
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      ctrl.raw <= '0;
      srcIdx   <= '0;
      srcMod   <= '0;
      srcCnt   <= '0;
      dstIdx   <= '0;
      dstMod   <= '0;
      dstCnt   <= '0;
      chainPtr <= '0;
    end
    else
    begin
      if (clrEnable)
        ctrl.f.enable <= 1'b0; // transfer finished
      if (srcStep)
      begin
        srcIdx <= srcIdx + srcMod;
        srcCnt <= srcCnt - 1'b1;
      end
      if (dstStep)
      begin
        dstIdx <= dstIdx + dstMod;
        dstCnt <= dstCnt - 1'b1;
      end
      if (ldWe)
      begin
        case (ldSel)
          SelSrcIdx:   srcIdx   <= ldAdrDat;
          SelSrcMod:   srcMod   <= ldAdrDat;
          SelSrcCnt:   srcCnt   <= ldDat;
          SelChainPtr: chainPtr <= ldAdrDat;
          SelDstIdx:   dstIdx   <= ldAdrDat;
          SelDstMod:   dstMod   <= ldAdrDat;
          SelDstCnt:   dstCnt   <= ldDat;
          default:     ;
        endcase
      end
      if (cfgWe)
      begin
        case (cfgAdr)
          RegCtrl:     ctrl.raw <= CtrlWidth'(cfgDat);
          RegSrcIdx:   srcIdx   <= cfgAdrDat;
          RegSrcMod:   srcMod   <= cfgAdrDat;
          RegSrcCnt:   srcCnt   <= cfgDat;
          RegDstIdx:   dstIdx   <= cfgAdrDat;
          RegDstMod:   dstMod   <= cfgAdrDat;
          RegDstCnt:   dstCnt   <= cfgDat;
          RegChainPtr: chainPtr <= cfgAdrDat;
          default:     ; // unknown offset
        endcase
      end
    end
  end

endmodule

// ==== rtl/dmaPkg.sv ====
package dmaPkg;

  // one word of address and one word of data
  localparam int AdrWidth  = 16;
  localparam int DataWidth = 16;

  localparam int DepthLog2 = 2; // four FIFO entries

  // register map, one address word each
  localparam logic [AdrWidth-1:0] RegCtrl     = 16'hFFF0;
  localparam logic [AdrWidth-1:0] RegSrcIdx   = 16'hFFF1;
  localparam logic [AdrWidth-1:0] RegSrcMod   = 16'hFFF2;
  localparam logic [AdrWidth-1:0] RegSrcCnt   = 16'hFFF3;
  localparam logic [AdrWidth-1:0] RegDstIdx   = 16'hFFF4;
  localparam logic [AdrWidth-1:0] RegDstMod   = 16'hFFF5;
  localparam logic [AdrWidth-1:0] RegDstCnt   = 16'hFFF6;
  localparam logic [AdrWidth-1:0] RegChainPtr = 16'hFFF9;

  localparam logic [1:0] ModeNormal = 2'b00;
  localparam logic [1:0] ModeChain  = 2'b01;

  // upper bit is the source port, lower bit the destination, 1 is system
  localparam logic [1:0] DirNearNear = 2'b00;
  localparam logic [1:0] DirNearSys  = 2'b01;
  localparam logic [1:0] DirSysNear  = 2'b10;
  localparam logic [1:0] DirSysSys   = 2'b11;

  localparam int DescWords = 7;

  // selector value equals the word position inside a descriptor
  typedef logic [2:0] RegSel;
  localparam RegSel SelSrcIdx   = 3'd0;
  localparam RegSel SelSrcMod   = 3'd1;
  localparam RegSel SelSrcCnt   = 3'd2;
  localparam RegSel SelChainPtr = 3'd3;
  localparam RegSel SelDstIdx   = 3'd4;
  localparam RegSel SelDstMod   = 3'd5;
  localparam RegSel SelDstCnt   = 3'd6;

  typedef union packed {
    logic [DataWidth-1:0] raw;
    struct packed {
      logic [DataWidth-7:0] rsvdHi;
      logic [1:0]           mode;
      logic [1:0]           dir;
      logic                 rsvd;
      logic                 enable;
    } f;
  } dmaCtrl_u;

endpackage
